//--- src/approx_mul_cfg.svh
`ifndef APPROX_MUL_CFG_SVH
`define APPROX_MUL_CFG_SVH

// operand and nibble widths
`define APPROX_MUL_OPW  8
`define APPROX_MUL_NIBW 4

// approximate low bits of the two top-level adders
// middle adder sums the cross products exactly
`define APPROX_MUL_TOP_MID_K 0
`define APPROX_MUL_TOP_FIN_K 3

`endif

//--- src/approx_mul_pkg.sv
`include "approx_mul_cfg.svh"

package approx_mul_pkg;

    // full operand
    typedef logic [`APPROX_MUL_OPW-1:0] operand_t;

    // one half of an operand
    typedef logic [`APPROX_MUL_NIBW-1:0] nibble_t;

    // product of two nibbles
    typedef logic [2*`APPROX_MUL_NIBW-1:0] pprod_t;

    // full product of two operands
    typedef logic [2*`APPROX_MUL_OPW-1:0] product_t;

endpackage

//--- src/pp_if.sv
`timescale 1ns/1ps

interface pp_if;
    import approx_mul_pkg::*;

    logic   valid;
    // partial products named by operand half, a first
    pprod_t pp_hh;
    pprod_t pp_hl;
    pprod_t pp_lh;
    pprod_t pp_ll;

    modport src (
        output valid,
        output pp_hh,
        output pp_hl,
        output pp_lh,
        output pp_ll
    );

    modport dst (
        input valid,
        input pp_hh,
        input pp_hl,
        input pp_lh,
        input pp_ll
    );

endinterface

//--- src/lower_or_adder.sv
`timescale 1ns/1ps

module lower_or_adder #(
    parameter int WIDTH       = 8,
    parameter int APPROX_BITS = 0
) (
    input  logic [WIDTH-1:0] x,
    input  logic [WIDTH-1:0] y,
    output logic [WIDTH:0]   sum
);

    generate
        if (APPROX_BITS == 0) begin : g_exact
            assign sum = {1'b0, x} + {1'b0, y};
        end else begin : g_approx
            // low part is OR only, so no carry reaches the upper part
            assign sum[APPROX_BITS-1:0] = x[APPROX_BITS-1:0] | y[APPROX_BITS-1:0];

            // upper part and carry out stay exact
            assign sum[WIDTH:APPROX_BITS] = {1'b0, x[WIDTH-1:APPROX_BITS]}
                                          + {1'b0, y[WIDTH-1:APPROX_BITS]};
        end
    endgenerate

endmodule

//--- src/split_mul_4x4.sv
`timescale 1ns/1ps
`include "approx_mul_cfg.svh"

module split_mul_4x4 #(
    parameter int HIGH_BITS = 1
) (
    input  approx_mul_pkg::nibble_t a,
    input  approx_mul_pkg::nibble_t b,
    output approx_mul_pkg::pprod_t  p
);
    import approx_mul_pkg::*;

    localparam int LOW_BITS = `APPROX_MUL_NIBW - HIGH_BITS;

    // a 1x1 product fits in one bit and a 2x2 product needs four
    localparam int HH_W  = (HIGH_BITS == 1) ? 1 : 2 * HIGH_BITS;
    localparam int LL_W  = 2 * LOW_BITS;
    localparam int MID_W = (HIGH_BITS == 1) ? LOW_BITS : HIGH_BITS + LOW_BITS;
    localparam int FIN_W = HH_W + LOW_BITS;
    localparam int FIN_K = (HIGH_BITS == 1) ? 0 : 1;

    logic [HIGH_BITS-1:0] ah;
    logic [HIGH_BITS-1:0] bh;
    logic [LOW_BITS-1:0]  al;
    logic [LOW_BITS-1:0]  bl;

    logic [HH_W-1:0]  hh;
    logic [MID_W-1:0] hl;
    logic [MID_W-1:0] lh;
    logic [LL_W-1:0]  ll;

    logic [MID_W:0]   mid_sum;
    logic [FIN_W-1:0] fin_x;
    logic [FIN_W-1:0] fin_y;
    logic [FIN_W:0]   fin_sum;

    assign ah = a[`APPROX_MUL_NIBW-1 -: HIGH_BITS];
    assign bh = b[`APPROX_MUL_NIBW-1 -: HIGH_BITS];
    assign al = a[LOW_BITS-1:0];
    assign bl = b[LOW_BITS-1:0];

    // small exact products
    assign hh = HH_W'(ah) * HH_W'(bh);
    assign hl = MID_W'(ah) * MID_W'(bl);
    assign lh = MID_W'(al) * MID_W'(bh);
    assign ll = LL_W'(al) * LL_W'(bl);

    lower_or_adder #(.WIDTH(MID_W), .APPROX_BITS(0)) mid_adder_inst (
        .x   (hl),
        .y   (lh),
        .sum (mid_sum)
    );

    assign fin_x = {hh, ll[LL_W-1:LOW_BITS]};
    assign fin_y = FIN_W'(mid_sum);

    lower_or_adder #(.WIDTH(FIN_W), .APPROX_BITS(FIN_K)) fin_adder_inst (
        .x   (fin_x),
        .y   (fin_y),
        .sum (fin_sum)
    );

    // bits above the nibble product width are dropped
    assign p = {fin_sum[2*`APPROX_MUL_NIBW-LOW_BITS-1:0], ll[LOW_BITS-1:0]};

endmodule

//--- src/pp_stage.sv
`timescale 1ns/1ps
`include "approx_mul_cfg.svh"

module pp_stage (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     in_valid,
    input  approx_mul_pkg::operand_t a,
    input  approx_mul_pkg::operand_t b,
    pp_if.src                        pp
);
    import approx_mul_pkg::*;

    localparam int NIBW = `APPROX_MUL_NIBW;

    nibble_t a_hi;
    nibble_t a_lo;
    nibble_t b_hi;
    nibble_t b_lo;

    pprod_t hh;
    pprod_t hl;
    pprod_t lh;
    pprod_t ll;

    assign a_hi = a[`APPROX_MUL_OPW-1 -: NIBW];
    assign a_lo = a[NIBW-1:0];
    assign b_hi = b[`APPROX_MUL_OPW-1 -: NIBW];
    assign b_lo = b[NIBW-1:0];

    // high by high with a 1/3 split
    split_mul_4x4 #(.HIGH_BITS(1)) hh_mul_inst (
        .a (a_hi),
        .b (b_hi),
        .p (hh)
    );

    // low a by high b with a 2/2 split
    split_mul_4x4 #(.HIGH_BITS(2)) lh_mul_inst (
        .a (a_lo),
        .b (b_hi),
        .p (lh)
    );

    assign hl = pprod_t'(a_hi) * pprod_t'(b_lo);
    assign ll = pprod_t'(a_lo) * pprod_t'(b_lo);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pp.valid <= 1'b0;
        end else begin
            pp.valid <= in_valid;
        end
    end

    // loaded every cycle and only meaningful while valid is high
    always_ff @(posedge clk) begin
        pp.pp_hh <= hh;
        pp.pp_hl <= hl;
        pp.pp_lh <= lh;
        pp.pp_ll <= ll;
    end

endmodule

//--- src/sum_stage.sv
`timescale 1ns/1ps
`include "approx_mul_cfg.svh"

module sum_stage (
    input  logic                     clk,
    input  logic                     rst_n,
    pp_if.dst                        pp,
    output logic                     out_valid,
    output approx_mul_pkg::product_t p
);
    import approx_mul_pkg::*;

    localparam int NIBW  = `APPROX_MUL_NIBW;
    localparam int MID_W = 2 * NIBW;
    localparam int FIN_W = `APPROX_MUL_OPW + NIBW;

    logic [MID_W:0]   mid_sum;
    logic [FIN_W-1:0] fin_x;
    logic [FIN_W-1:0] fin_y;
    logic [FIN_W:0]   fin_sum;
    product_t         p_next;

    // cross products
    lower_or_adder #(
        .WIDTH       (MID_W),
        .APPROX_BITS (`APPROX_MUL_TOP_MID_K)
    ) mid_adder_inst (
        .x   (pp.pp_hl),
        .y   (pp.pp_lh),
        .sum (mid_sum)
    );

    assign fin_x = {pp.pp_hh, pp.pp_ll[MID_W-1:NIBW]};
    assign fin_y = FIN_W'(mid_sum);

    lower_or_adder #(
        .WIDTH       (FIN_W),
        .APPROX_BITS (`APPROX_MUL_TOP_FIN_K)
    ) fin_adder_inst (
        .x   (fin_x),
        .y   (fin_y),
        .sum (fin_sum)
    );

    // carry out of the final adder is dropped
    assign p_next = {fin_sum[FIN_W-1:0], pp.pp_ll[NIBW-1:0]};

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
            p         <= '0;
        end else begin
            out_valid <= pp.valid;
            if (pp.valid) begin
                p <= p_next;
            end
        end
    end

endmodule

//--- src/approx_mul_top.sv
`timescale 1ns/1ps

module approx_mul_top (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     in_valid,
    input  approx_mul_pkg::operand_t a,
    input  approx_mul_pkg::operand_t b,
    output logic                     out_valid,
    output approx_mul_pkg::product_t p
);

    // registered partial products between the stages
    pp_if pp_if_inst ();

    pp_stage pp_stage_inst (
        .clk      (clk),
        .rst_n    (rst_n),
        .in_valid (in_valid),
        .a        (a),
        .b        (b),
        .pp       (pp_if_inst.src)
    );

    sum_stage sum_stage_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .pp        (pp_if_inst.dst),
        .out_valid (out_valid),
        .p         (p)
    );

endmodule

//--- sim/approx_mul_sva.sv
`timescale 1ns/1ps

module approx_mul_sva (
    input logic                     clk,
    input logic                     rst_n,
    input logic                     in_valid,
    input logic                     out_valid,
    input approx_mul_pkg::product_t p
);

    // strobe is quiet through reset
    reset_quiet_a: assert property (@(posedge clk) $past(!rst_n) |-> !out_valid)
        else $error("out_valid high after a cycle with reset asserted");

    // and stays quiet one cycle past it
    reset_after_a: assert property (@(posedge clk) $past(!rst_n, 2) |-> !out_valid)
        else $error("out_valid high in the cycle after reset");

    latency_a: assert property (@(posedge clk) disable iff (!rst_n)
        ($past(rst_n) && $past(rst_n, 2)) |-> (out_valid == $past(in_valid, 2)))
        else $error("out_valid does not follow in_valid by two cycles");

    known_a: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid |-> !$isunknown(p))
        else $error("product has unknown bits while out_valid is high");

endmodule

bind approx_mul_top approx_mul_sva approx_mul_sva_inst (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (in_valid),
    .out_valid (out_valid),
    .p         (p)
);

//--- sim/approx_mul_tb.sv
`timescale 1ns/1ps

module approx_mul_tb;
    import approx_mul_pkg::*;

    localparam int CLK_PERIOD    = 4;
    localparam int RESET_CYCLES  = 10;
    localparam int ZERO_OPS      = 12;
    localparam int SMALL_OPS     = 16;
    localparam int BURST_OPS     = 15;
    localparam int CORNER_OPS    = 6;
    localparam int RAND_OPS      = 320;
    localparam int N_OPS         = ZERO_OPS + SMALL_OPS + BURST_OPS + CORNER_OPS + RAND_OPS;
    localparam int MARGIN_CYCLES = 200;
    localparam int WATCHDOG_CYCLES = N_OPS + RESET_CYCLES + MARGIN_CYCLES;

    logic     clk;
    logic     rst_n;
    logic     in_valid;
    operand_t a;
    operand_t b;
    logic     out_valid;
    product_t p;

    logic [15:0] lfsr = 16'd68;

    // expected results in issue order
    product_t exp_q[$];
    product_t exact_val_q[$];
    bit       exact_q[$];

    // outputs captured at the falling edge and checked at the next rising edge
    product_t p_seen    = '0;
    product_t p_prev    = '0;
    logic     ov_seen   = 1'b0;
    logic     chk       = 1'b0;
    logic     chk_exact = 1'b0;
    product_t exp_p     = '0;
    product_t exact_p   = '0;
    int       issued    = 0;

    int err_value = 0;
    int err_exact = 0;
    int err_idle  = 0;
    int err_ovq   = 0;
    int err_hold  = 0;
    int err_queue = 0;

    approx_mul_top approx_mul_top_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .a         (a),
        .b         (b),
        .out_valid (out_valid),
        .p         (p)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    function automatic logic [15:0] next_lfsr(input logic [15:0] s);
        return {1'b0, s[15:1]} ^ (s[0] ? 16'hB400 : 16'h0000);
    endfunction

    task automatic rand_bits(input int n, output logic [7:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[6:0], lfsr[0]};
            lfsr = next_lfsr(lfsr);
        end
    endtask

    // low k bits are OR and the upper part is exact with its carry kept
    function automatic int or_add(input int x, input int y, input int k);
        int low;
        int high;
        low  = (x | y) & ((1 << k) - 1);
        high = ((x >> k) + (y >> k)) << k;
        return high | low;
    endfunction

    function automatic int split_product(input int x, input int y, input int high_bits);
        int low_bits;
        int xh;
        int xl;
        int yh;
        int yl;
        int ll;
        int mid;
        int fin;
        low_bits = 4 - high_bits;
        xh  = x >> low_bits;
        yh  = y >> low_bits;
        xl  = x & ((1 << low_bits) - 1);
        yl  = y & ((1 << low_bits) - 1);
        ll  = xl * yl;
        mid = xh * yl + xl * yh;
        // 1/3 split adds exactly while 2/2 split ORs its lowest bit
        fin = or_add(((xh * yh) << low_bits) | (ll >> low_bits), mid,
                     (high_bits == 1) ? 0 : 1);
        return ((fin & ((1 << (8 - low_bits)) - 1)) << low_bits)
             | (ll & ((1 << low_bits) - 1));
    endfunction

    function automatic product_t approx_product(input operand_t op_a, input operand_t op_b);
        int ah;
        int al;
        int bh;
        int bl;
        int ll;
        int fin;
        int res;
        ah  = int'(op_a[7:4]);
        al  = int'(op_a[3:0]);
        bh  = int'(op_b[7:4]);
        bl  = int'(op_b[3:0]);
        ll  = al * bl;
        fin = or_add((split_product(ah, bh, 1) << 4) | (ll >> 4),
                     ah * bl + split_product(al, bh, 2), 3);
        // carry out of bit 12 is dropped
        res = ((fin & 'hFFF) << 4) | (ll & 'hF);
        return res[15:0];
    endfunction

    task automatic issue(input operand_t op_a, input operand_t op_b);
        @(posedge clk);
        #1;
        in_valid = 1'b1;
        a = op_a;
        b = op_b;
    endtask

    // operands keep moving while idle so the held product is exercised
    task automatic idle(input int n);
        repeat (n) begin
            @(posedge clk);
            #1;
            in_valid = 1'b0;
            a = ~a;
            b = ~b;
        end
    endtask

    always @(negedge clk) begin
        p_prev    <= p_seen;
        p_seen    <= p;
        ov_seen   <= out_valid;
        chk       <= 1'b0;
        chk_exact <= 1'b0;
        if (out_valid) begin
            if (exp_q.size() == 0) begin
                err_queue <= err_queue + 1;
                $display("ERROR: out_valid seen with no operation pending");
            end else begin
                chk       <= 1'b1;
                exp_p     <= exp_q.pop_front();
                exact_p   <= exact_val_q.pop_front();
                chk_exact <= exact_q.pop_front();
            end
        end
        // in_valid here is what the DUT samples at the next rising edge
        if (in_valid && rst_n) begin
            exp_q.push_back(approx_product(a, b));
            exact_val_q.push_back(16'(a) * 16'(b));
            exact_q.push_back((a == '0) || (b == '0) || (a < 8'd16 && b < 8'd16));
            issued <= issued + 1;
        end
    end

    value_a: assert property (@(posedge clk) disable iff (!rst_n) chk |-> (p_seen == exp_p))
        else begin
            err_value = err_value + 1;
            $display("MISMATCH p: got %h expected %h", p_seen, exp_p);
        end

    exact_a: assert property (@(posedge clk) disable iff (!rst_n)
        (chk && chk_exact) |-> (p_seen == exact_p))
        else begin
            err_exact = err_exact + 1;
            $display("MISMATCH p: got %h expected exact %h", p_seen, exact_p);
        end

    idle_p_a: assert property (@(posedge clk) disable iff (!rst_n)
        (issued == 0) |-> (p_seen == '0))
        else begin
            err_idle = err_idle + 1;
            $display("MISMATCH p: got %h expected 0000 before first operation", p_seen);
        end

    idle_ov_a: assert property (@(posedge clk) disable iff (!rst_n) (issued == 0) |-> !ov_seen)
        else begin
            err_ovq = err_ovq + 1;
            $display("ERROR: out_valid went high before any operation was issued");
        end

    hold_a: assert property (@(posedge clk) disable iff (!rst_n) !ov_seen |-> (p_seen == p_prev))
        else begin
            err_hold = err_hold + 1;
            $display("MISMATCH p: got %h expected held %h", p_seen, p_prev);
        end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("ERROR: watchdog expired with %0d operations still pending", exp_q.size());
        $display("Test failures found");
        $finish;
    end

    initial begin
        operand_t ra;
        operand_t rb;
        int       total;
        rst_n    = 1'b0;
        in_valid = 1'b0;
        a        = '0;
        b        = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rst_n = 1'b1;
        idle(4);

        // zero operands back to back
        issue(8'h00, 8'h00);
        issue(8'h00, 8'hFF);
        issue(8'hFF, 8'h00);
        issue(8'h00, 8'h80);
        for (int i = 0; i < 4; i++) begin
            rand_bits(8, ra);
            issue(ra, 8'h00);
            rand_bits(8, rb);
            issue(8'h00, rb);
        end
        idle(3);

        // small operands with one strobe every other cycle
        issue(8'h0F, 8'h0F);
        idle(1);
        for (int i = 1; i < SMALL_OPS; i++) begin
            rand_bits(4, ra);
            rand_bits(4, rb);
            issue(ra, rb);
            idle(1);
        end

        // bursts of growing length with gaps between
        for (int len = 1; len <= 5; len++) begin
            for (int j = 0; j < len; j++) begin
                rand_bits(8, ra);
                rand_bits(8, rb);
                issue(ra, rb);
            end
            idle(len);
        end

        issue(8'hFF, 8'hFF);
        issue(8'hFF, 8'h01);
        issue(8'h01, 8'hFF);
        issue(8'hF0, 8'hF0);
        issue(8'h0F, 8'hF0);
        issue(8'h80, 8'h80);

        for (int i = 0; i < RAND_OPS; i++) begin
            rand_bits(8, ra);
            rand_bits(8, rb);
            issue(ra, rb);
            if (i % 8 == 7) begin
                idle(1);
            end
        end
        idle(1);

        while (exp_q.size() != 0) begin
            @(posedge clk);
        end
        idle(3);

        total = err_value + err_exact + err_idle + err_ovq + err_hold + err_queue;
        $display("ops=%0d value=%0d exact=%0d idle=%0d ov=%0d hold=%0d queue=%0d errors=%0d",
                 issued, err_value, err_exact, err_idle, err_ovq, err_hold, err_queue, total);
        if (total == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

//--- approx_mul.f
+incdir+src
src/approx_mul_pkg.sv
src/pp_if.sv
src/lower_or_adder.sv
src/split_mul_4x4.sv
src/pp_stage.sv
src/sum_stage.sv
src/approx_mul_top.sv
sim/approx_mul_sva.sv
sim/approx_mul_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    --top-module approx_mul_tb \
    -f approx_mul.f \
    -o approx_mul_sim

sim_out=$(./obj_dir/approx_mul_sim 2>&1) || true
echo "$sim_out"

if ! grep -q 'All tests passed!' <<< "$sim_out"; then
    echo "simulation did not pass"
    exit 1
fi
exit 0
